/* flist.f */
hw/QuplsIsaPkg.sv
hw/QuplsDecodePkg.sv
hw/QuplsDecodeHasImm.sv
hw/QuplsInstrAligner.sv
hw/QuplsInstrQueue.sv
hw/QuplsDecoder.sv
hw/QuplsDecodeTop.sv
verification/QuplsDecodeTb.sv

/* run.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module QuplsDecodeTb \
	-Mdir obj_dir -o QuplsDecodeSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/QuplsDecodeSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* verification/QuplsDecodeTb.sv */
`timescale 1ns/1ps
`default_nettype none

module QuplsDecodeTb;

	// Limits for every wait loop, counted in clock cycles
	localparam int TIMEOUT_CYCLES = 50;
	localparam int IDLE_CYCLES = 20;
	// Odd count keeps the instruction total even, since every block holds a pair
	localparam int RANDOM_ENTRIES = 9;
	localparam int FIRST_LATENCY = 3;

	logic clk;
	logic rst;
	logic fetchValid;
	QuplsIsaPkg::fetchBlock fetchBlk;
	QuplsDecodePkg::address_t fetchPc;
	logic fetchBusy;
	logic decodedValid;
	QuplsDecodePkg::address_t decodedPc;
	QuplsIsaPkg::opcode_t opcode;
	QuplsDecodePkg::regNum_t rd;
	QuplsDecodePkg::regNum_t rs1;
	QuplsDecodePkg::regNum_t rs2;
	logic hasImm;
	QuplsDecodePkg::immValue_t imm;
	logic isMem;

	// Opcode table with the classification expected for each opcode
	QuplsIsaPkg::opcode_t opList[$];
	bit opImm[$];
	bit opMem[$];

	// Expected table, one bundle per instruction in address order
	string expName[$];
	QuplsIsaPkg::instrWord instrList[$];
	QuplsIsaPkg::opcode_t expOp[$];
	QuplsDecodePkg::regNum_t expRd[$];
	QuplsDecodePkg::regNum_t expRs1[$];
	QuplsDecodePkg::regNum_t expRs2[$];
	bit expHasImm[$];
	QuplsDecodePkg::immValue_t expImm[$];
	bit expIsMem[$];
	QuplsDecodePkg::address_t expPc[$];

	// Stimulus table of fetch blocks and their addresses
	QuplsIsaPkg::fetchBlock blkTable[$];
	QuplsDecodePkg::address_t pcTable[$];

	integer seed;
	int cycleCount = 0;
	int firstDriveCycle = 0;
	bit anyError = 1'b0;

	QuplsDecodeTop i_QuplsDecodeTop
	(
		.clk(clk),
		.rst(rst),
		.fetchValid(fetchValid),
		.fetchBlk(fetchBlk),
		.fetchPc(fetchPc),
		.fetchBusy(fetchBusy),
		.decodedValid(decodedValid),
		.decodedPc(decodedPc),
		.opcode(opcode),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.hasImm(hasImm),
		.imm(imm),
		.isMem(isMem)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Counts rising edges so latency can be measured from the falling edge
	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	// ========================================================================
	// Failure reporting and compares
	// ========================================================================

	task automatic stopWithFailure(input string what);
		anyError = 1'b1;
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compareOpcode(input string testName, input QuplsIsaPkg::opcode_t expected,
		input QuplsIsaPkg::opcode_t actual);
		if (expected !== actual)
			stopWithFailure($sformatf("FAILED %s opcode: expected %h, actual %h",
				testName, expected, actual));
	endtask

	task automatic compareReg(input string testName, input string field,
		input QuplsDecodePkg::regNum_t expected, input QuplsDecodePkg::regNum_t actual);
		if (expected !== actual)
			stopWithFailure($sformatf("FAILED %s %s: expected %0d, actual %0d",
				testName, field, expected, actual));
	endtask

	task automatic compareImm(input string testName, input QuplsDecodePkg::immValue_t expected,
		input QuplsDecodePkg::immValue_t actual);
		if (expected !== actual)
			stopWithFailure($sformatf("FAILED %s imm: expected %h, actual %h",
				testName, expected, actual));
	endtask

	task automatic compareAddr(input string testName, input QuplsDecodePkg::address_t expected,
		input QuplsDecodePkg::address_t actual);
		if (expected !== actual)
			stopWithFailure($sformatf("FAILED %s pc: expected %h, actual %h",
				testName, expected, actual));
	endtask

	task automatic compareBit(input string testName, input string field, input logic expected,
		input logic actual);
		if (expected !== actual)
			stopWithFailure($sformatf("FAILED %s %s: expected %b, actual %b",
				testName, field, expected, actual));
	endtask

	// ========================================================================
	// Table construction
	// ========================================================================

	task automatic addOp(input QuplsIsaPkg::opcode_t op, input bit immExp, input bit memExp);
		opList.push_back(op);
		opImm.push_back(immExp);
		opMem.push_back(memExp);
	endtask

	// Field layout is imm or Rs2 on top, then Rs1, Rd and the opcode
	task automatic addInstr(input string name, input int opIdx, input QuplsDecodePkg::regNum_t rdV,
		input QuplsDecodePkg::regNum_t rs1V, input logic [QuplsIsaPkg::IMM_FIELD_W-1:0] field);
		QuplsIsaPkg::opcode_t op;
		op = opList[opIdx];
		expName.push_back(name);
		instrList.push_back({field, rs1V, rdV, op});
		expOp.push_back(op);
		expRd.push_back(rdV);
		expRs1.push_back(rs1V);
		expHasImm.push_back(opImm[opIdx]);
		expIsMem.push_back(opMem[opIdx]);
		// With an immediate the Rs2 bits are part of it and read back as zero
		if (opImm[opIdx])
		begin
			expRs2.push_back('0);
			// The field read as a signed number gives the widened value
			expImm.push_back(QuplsDecodePkg::immValue_t'($signed(field)));
		end
		else
		begin
			expRs2.push_back(field[5:0]);
			expImm.push_back('0);
		end
	endtask

	task automatic buildTables();
		int i;
		int k;
		logic [31:0] r;
		QuplsDecodePkg::address_t pc;
		addOp(QuplsIsaPkg::OP_ZSxxI, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_ADDI, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_CMPI, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_MULI, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_DIVI, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_SUBFI, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_DIVUI, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_MULUI, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_ANDI, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_ORI, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_EORI, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_RTD, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_JSR, 1'b1, 1'b0);
		addOp(QuplsIsaPkg::OP_LDB, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_LDBU, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_LDW, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_LDWU, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_LDT, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_LDTU, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_LDO, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_CACHE, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_STB, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_STW, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_STT, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_STO, 1'b1, 1'b1);
		addOp(QuplsIsaPkg::OP_ADD, 1'b0, 1'b0);
		addOp(QuplsIsaPkg::OP_SUB, 1'b0, 1'b0);
		addOp(QuplsIsaPkg::OP_AND, 1'b0, 1'b0);
		addOp(QuplsIsaPkg::OP_OR, 1'b0, 1'b0);
		addOp(QuplsIsaPkg::OP_NOP, 1'b0, 1'b0);
		// Immediate forms get one positive and one negative field each
		for (i = 0; i < opList.size(); i++)
		begin
			if (opImm[i])
			begin
				addInstr($sformatf("%s_pos", opList[i].name()), i, 6'((i * 7 + 1) % 64),
					6'((i * 11 + 5) % 64), {1'b0, 12'((i * 37 + 3) % 4096)});
				addInstr($sformatf("%s_neg", opList[i].name()), i, 6'((i * 13 + 2) % 64),
					6'((i * 5 + 9) % 64), {1'b1, 12'((i * 53 + 1) % 4096)});
			end
			else
				addInstr($sformatf("%s_reg", opList[i].name()), i, 6'((i * 7 + 3) % 64),
					6'((i * 3 + 17) % 64), 13'((i * 29 + 2) % 8192));
		end
		// Random register fields and immediates on randomly picked opcodes
		for (i = 0; i < RANDOM_ENTRIES; i++)
		begin
			r = $random(seed);
			k = int'(r[7:0]) % opList.size();
			r = $random(seed);
			addInstr($sformatf("rand%0d_%s", i, opList[k].name()), k, r[5:0], r[11:6],
				r[24:12]);
		end
		// Pair instructions into blocks, lower address in the low half
		for (k = 0; k < instrList.size() / 2; k++)
		begin
			pc = 64'h8000_0000_0010_0000 + QuplsDecodePkg::address_t'(k * 16);
			blkTable.push_back({instrList[2 * k + 1], instrList[2 * k]});
			pcTable.push_back(pc);
			expPc.push_back(pc);
			expPc.push_back(pc + 64'd4);
		end
	endtask

	// ========================================================================
	// Driver and checker
	// ========================================================================

	// Blocks go out back to back, each as soon as fetchBusy drops
	task automatic driveBlocks();
		int k;
		int waited;
		for (k = 0; k < blkTable.size(); k++)
		begin
			waited = 0;
			while (fetchBusy !== 1'b0)
			begin
				waited++;
				if (waited > TIMEOUT_CYCLES)
					stopWithFailure($sformatf("Timeout: fetchBusy never dropped for block %0d", k));
				@(negedge clk);
			end
			fetchValid = 1'b1;
			fetchBlk = blkTable[k];
			fetchPc = pcTable[k];
			if (k == 0)
				firstDriveCycle = cycleCount;
			@(negedge clk);
			fetchValid = 1'b0;
			// The block was taken at the edge just passed, so the aligner is now busy
			compareBit($sformatf("block%0d", k), "fetchBusy", 1'b1, fetchBusy);
		end
	endtask

	task automatic waitDecoded(input int idx);
		int waited;
		waited = 0;
		@(negedge clk);
		while (decodedValid !== 1'b1)
		begin
			waited++;
			if (waited > TIMEOUT_CYCLES)
				stopWithFailure($sformatf("Timeout: no decoded bundle for entry %0d", idx));
			@(negedge clk);
		end
	endtask

	task automatic checkBundles();
		int i;
		int latency;
		for (i = 0; i < expName.size(); i++)
		begin
			waitDecoded(i);
			if (i == 0)
			begin
				latency = cycleCount - firstDriveCycle;
				if (latency != FIRST_LATENCY)
					stopWithFailure($sformatf("FAILED first_latency: expected %0d, actual %0d",
						FIRST_LATENCY, latency));
			end
			compareAddr(expName[i], expPc[i], decodedPc);
			compareOpcode(expName[i], expOp[i], opcode);
			compareReg(expName[i], "rd", expRd[i], rd);
			compareReg(expName[i], "rs1", expRs1[i], rs1);
			compareReg(expName[i], "rs2", expRs2[i], rs2);
			compareBit(expName[i], "hasImm", expHasImm[i], hasImm);
			compareImm(expName[i], expImm[i], imm);
			compareBit(expName[i], "isMem", expIsMem[i], isMem);
		end
	endtask

	// Nothing more may come out once the table is used up
	task automatic checkQuiet();
		int waited;
		for (waited = 0; waited < IDLE_CYCLES; waited++)
		begin
			@(negedge clk);
			if (decodedValid !== 1'b0)
				stopWithFailure("Unexpected decoded bundle after the last instruction");
		end
	endtask

	initial
	begin
		seed = 32'h4bec;
		rst = 1'b1;
		fetchValid = 1'b0;
		fetchBlk = '0;
		fetchPc = '0;
		buildTables();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		fork
			driveBlocks();
			checkBundles();
		join
		checkQuiet();
		if (!anyError)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
			stopWithFailure("Run ended with failed checks");
	end

endmodule

`default_nettype wire

/* hw/QuplsDecodeTop.sv */
`timescale 1ns/1ps
`default_nettype none

module QuplsDecodeTop
(
	input logic clk,
	input logic rst,
	input logic fetchValid,
	input QuplsIsaPkg::fetchBlock fetchBlk,
	input QuplsDecodePkg::address_t fetchPc,
	output logic fetchBusy,
	output logic decodedValid,
	output QuplsDecodePkg::address_t decodedPc,
	output QuplsIsaPkg::opcode_t opcode,
	output QuplsDecodePkg::regNum_t rd,
	output QuplsDecodePkg::regNum_t rs1,
	output QuplsDecodePkg::regNum_t rs2,
	output logic hasImm,
	output QuplsDecodePkg::immValue_t imm,
	output logic isMem
);

	// Aligner to queue
	wire wrEn;
	wire QuplsIsaPkg::instrWord wrInstr;
	wire QuplsDecodePkg::address_t wrPc;
	wire full;

	// Queue to decoder
	wire rdEn;
	wire empty;
	wire QuplsIsaPkg::instrWord rdInstr;
	wire QuplsDecodePkg::address_t rdPc;

	// ========================================================================
	// Aligner, queue and decoder in a line
	// ========================================================================

	QuplsInstrAligner aligner
	(
		.clk(clk),
		.rst(rst),
		.fetchValid(fetchValid),
		.fetchBlk(fetchBlk),
		.fetchPc(fetchPc),
		.full(full),
		.fetchBusy(fetchBusy),
		.wrEn(wrEn),
		.wrInstr(wrInstr),
		.wrPc(wrPc)
	);

	QuplsInstrQueue #(.DEPTH(QuplsDecodePkg::QUEUE_DEPTH)) instrQueue
	(
		.clk(clk),
		.rst(rst),
		.wrEn(wrEn),
		.wrInstr(wrInstr),
		.wrPc(wrPc),
		.rdEn(rdEn),
		.rdInstr(rdInstr),
		.rdPc(rdPc),
		.full(full),
		.empty(empty)
	);

	QuplsDecoder decoder
	(
		.clk(clk),
		.rst(rst),
		.empty(empty),
		.rdInstr(rdInstr),
		.rdPc(rdPc),
		.rdEn(rdEn),
		.decodedValid(decodedValid),
		.decodedPc(decodedPc),
		.opcode(opcode),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.hasImm(hasImm),
		.imm(imm),
		.isMem(isMem)
	);

endmodule

`default_nettype wire

/* hw/QuplsDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module QuplsDecoder
(
	input logic clk,
	input logic rst,
	input logic empty,
	input QuplsIsaPkg::instrWord rdInstr,
	input QuplsDecodePkg::address_t rdPc,
	output logic rdEn,
	output logic decodedValid,
	output QuplsDecodePkg::address_t decodedPc,
	output QuplsIsaPkg::opcode_t opcode,
	output QuplsDecodePkg::regNum_t rd,
	output QuplsDecodePkg::regNum_t rs1,
	output QuplsDecodePkg::regNum_t rs2,
	output logic hasImm,
	output QuplsDecodePkg::immValue_t imm,
	output logic isMem
);

	// Number of copies of the sign bit needed to fill the machine word
	localparam int IMM_EXT_W = QuplsDecodePkg::IMM_W - QuplsIsaPkg::IMM_FIELD_W;

	logic headHasImm;
	logic headIsMem;
	logic immSign;
	QuplsIsaPkg::opcode_t headOp;
	QuplsDecodePkg::regNum_t headRs2;
	QuplsDecodePkg::immValue_t headImm;

	// ========================================================================
	// Combinational decode of the queue head
	// ========================================================================

	QuplsDecodeHasImm hasImmUnit
	(
		.instr(rdInstr),
		.hasImm(headHasImm)
	);

	function automatic logic isMemOpcode(input QuplsIsaPkg::opcode_t code);
		logic result;
		result = 1'b0;
		case (code)
		// Loads and the cache control op both generate an address
		QuplsIsaPkg::OP_LDB, QuplsIsaPkg::OP_LDBU, QuplsIsaPkg::OP_LDW,
		QuplsIsaPkg::OP_LDWU, QuplsIsaPkg::OP_LDT, QuplsIsaPkg::OP_LDTU,
		QuplsIsaPkg::OP_LDO, QuplsIsaPkg::OP_CACHE:
			result = 1'b1;
		QuplsIsaPkg::OP_STB, QuplsIsaPkg::OP_STW, QuplsIsaPkg::OP_STT,
		QuplsIsaPkg::OP_STO:
			result = 1'b1;
		default:
			result = 1'b0;
		endcase
		return result;
	endfunction

	// Pop whenever something is waiting, one instruction per cycle
	assign rdEn = !empty;

	assign headOp = QuplsIsaPkg::opcode_t'(rdInstr[QuplsIsaPkg::OPCODE_MSB:QuplsIsaPkg::OPCODE_LSB]);
	assign headIsMem = isMemOpcode(headOp);
	assign immSign = rdInstr[QuplsIsaPkg::IMM_MSB];

	// Rs2 bits belong to the immediate when one is present
	assign headRs2 = headHasImm ? '0 : rdInstr[QuplsIsaPkg::RS2_MSB:QuplsIsaPkg::RS2_LSB];
	assign headImm = headHasImm
		? {{IMM_EXT_W{immSign}}, rdInstr[QuplsIsaPkg::IMM_MSB:QuplsIsaPkg::IMM_LSB]} : '0;

	// ========================================================================
	// Bundle registers
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
			decodedValid <= 1'b0;
		else
			decodedValid <= rdEn;
	end

	// Bundle only changes on a pop, so it stays stable between strobes
	always_ff @(posedge clk)
	begin
		if (rdEn)
		begin
			decodedPc <= rdPc;
			opcode <= headOp;
			rd <= rdInstr[QuplsIsaPkg::RD_MSB:QuplsIsaPkg::RD_LSB];
			rs1 <= rdInstr[QuplsIsaPkg::RS1_MSB:QuplsIsaPkg::RS1_LSB];
			rs2 <= headRs2;
			hasImm <= headHasImm;
			imm <= headImm;
			isMem <= headIsMem;
		end
	end

endmodule

`default_nettype wire

/* hw/QuplsInstrQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module QuplsInstrQueue
#(
	parameter int DEPTH = QuplsDecodePkg::QUEUE_DEPTH
)
(
	input logic clk,
	input logic rst,
	input logic wrEn,
	input QuplsIsaPkg::instrWord wrInstr,
	input QuplsDecodePkg::address_t wrPc,
	input logic rdEn,
	output QuplsIsaPkg::instrWord rdInstr,
	output QuplsDecodePkg::address_t rdPc,
	output logic full,
	output logic empty
);

	// Pointers wrap on their own since DEPTH is a power of two
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	QuplsIsaPkg::instrWord instrMem [DEPTH];
	QuplsDecodePkg::address_t pcMem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic doWrite;
	logic doRead;

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign doWrite = wrEn && !full;
	assign doRead = rdEn && !empty;

	// Head entry is shown directly, so a fresh entry is readable the cycle after its write
	assign rdInstr = instrMem[rdPtr];
	assign rdPc = pcMem[rdPtr];

	// ========================================================================
	// Storage and pointers
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (doWrite)
		begin
			instrMem[wrPtr] <= wrInstr;
			pcMem[wrPtr] <= wrPc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			// A read and a write on the same edge leave the count unchanged
			if (doWrite && !doRead)
				count <= count + 1'b1;
			else if (doRead && !doWrite)
				count <= count - 1'b1;
		end
	end

	// Both neighbours are expected to look at the flags before strobing
	assert property (@(posedge clk) disable iff (rst) wrEn |-> !full)
		else $error("QuplsInstrQueue: write while full");
	assert property (@(posedge clk) disable iff (rst) rdEn |-> !empty)
		else $error("QuplsInstrQueue: read while empty");

endmodule

`default_nettype wire

/* hw/QuplsInstrAligner.sv */
`timescale 1ns/1ps
`default_nettype none

module QuplsInstrAligner
(
	input logic clk,
	input logic rst,
	input logic fetchValid,
	input QuplsIsaPkg::fetchBlock fetchBlk,
	input QuplsDecodePkg::address_t fetchPc,
	input logic full,
	output logic fetchBusy,
	output logic wrEn,
	output QuplsIsaPkg::instrWord wrInstr,
	output QuplsDecodePkg::address_t wrPc
);

	// IDLE waits for a block, FIRST owes the low half, SECOND owes the high half
	typedef enum logic [1:0] {IDLE, FIRST, SECOND} alignState_t;

	alignState_t state;
	QuplsIsaPkg::fetchBlock blkReg;
	QuplsDecodePkg::address_t pcReg;
	logic accept;

	// Busy for as long as any half of the block is still owed to the queue
	assign fetchBusy = (state != IDLE);
	assign accept = fetchValid && !fetchBusy;

	// A write goes out on every edge where the queue has room
	assign wrEn = fetchBusy && !full;

	// The high half is the instruction one word further on
	assign wrInstr = (state == SECOND) ? blkReg[QuplsIsaPkg::FETCH_W-1:QuplsIsaPkg::INSTR_W]
		: blkReg[QuplsIsaPkg::INSTR_W-1:0];
	assign wrPc = (state == SECOND)
		? pcReg + QuplsDecodePkg::address_t'(QuplsDecodePkg::INSTR_BYTES) : pcReg;

	// ========================================================================
	// Control
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= IDLE;
		else
		begin
			case (state)
			IDLE:
				if (accept)
					state <= FIRST;
			// Stay put while the queue is full, so the instruction is held
			FIRST:
				if (!full)
					state <= SECOND;
			SECOND:
				if (!full)
					state <= IDLE;
			default:
				state <= IDLE;
			endcase
		end
	end

	// Block and address are captured once and held until both halves are out
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			blkReg <= fetchBlk;
			pcReg <= fetchPc;
		end
	end

	// The fetch unit has to respect fetchBusy, a strobe while busy is dropped
	assert property (@(posedge clk) disable iff (rst) fetchValid |-> !fetchBusy)
		else $error("QuplsInstrAligner: fetch strobe while busy");

endmodule

`default_nettype wire

/* hw/QuplsDecodeHasImm.sv */
`timescale 1ns/1ps
`default_nettype none

module QuplsDecodeHasImm
(
	input QuplsIsaPkg::instrWord instr,
	output logic hasImm
);

	QuplsIsaPkg::opcode_t op;

	// Opcode values outside the enum fall through to the default below
	assign op = QuplsIsaPkg::opcode_t'(instr[QuplsIsaPkg::OPCODE_MSB:QuplsIsaPkg::OPCODE_LSB]);

	// ========================================================================
	// Immediate classification
	// ========================================================================

	function automatic logic isImmOpcode(input QuplsIsaPkg::opcode_t code);
		logic result;
		result = 1'b0;
		case (code)
		// Set on condition against an immediate
		QuplsIsaPkg::OP_ZSxxI:
			result = 1'b1;
		// Arithmetic and logic with an immediate second operand
		QuplsIsaPkg::OP_ADDI, QuplsIsaPkg::OP_CMPI, QuplsIsaPkg::OP_MULI,
		QuplsIsaPkg::OP_DIVI, QuplsIsaPkg::OP_SUBFI, QuplsIsaPkg::OP_DIVUI,
		QuplsIsaPkg::OP_MULUI, QuplsIsaPkg::OP_ANDI, QuplsIsaPkg::OP_ORI,
		QuplsIsaPkg::OP_EORI:
			result = 1'b1;
		// Return-and-deallocate carries the stack adjustment, JSR the target offset
		QuplsIsaPkg::OP_RTD, QuplsIsaPkg::OP_JSR:
			result = 1'b1;
		// Memory operations use the immediate as the address displacement
		QuplsIsaPkg::OP_LDB, QuplsIsaPkg::OP_LDBU, QuplsIsaPkg::OP_LDW,
		QuplsIsaPkg::OP_LDWU, QuplsIsaPkg::OP_LDT, QuplsIsaPkg::OP_LDTU,
		QuplsIsaPkg::OP_LDO, QuplsIsaPkg::OP_CACHE, QuplsIsaPkg::OP_STB,
		QuplsIsaPkg::OP_STW, QuplsIsaPkg::OP_STT, QuplsIsaPkg::OP_STO:
			result = 1'b1;
		// Register-only forms read Rs2 instead
		default:
			result = 1'b0;
		endcase
		return result;
	endfunction

	assign hasImm = isImmOpcode(op);

endmodule

`default_nettype wire

/* hw/QuplsDecodePkg.sv */
`default_nettype none

package QuplsDecodePkg;

	// ========================================================================
	// Decode stage types
	// ========================================================================

	// Instruction addresses span the full 64-bit space
	localparam int ADDR_W = 64;

	// Immediates are widened to the machine word before leaving decode
	localparam int IMM_W = 64;

	typedef logic [ADDR_W-1:0] address_t;

	// Register numbers share their width with the instruction fields
	typedef logic [QuplsIsaPkg::REG_FIELD_W-1:0] regNum_t;

	typedef logic [IMM_W-1:0] immValue_t;

	// ========================================================================
	// Decode stage sizing
	// ========================================================================

	// Four entries hold two whole fetch blocks
	localparam int QUEUE_DEPTH = 4;

	// Byte distance between the two instructions of one block
	localparam int INSTR_BYTES = 4;

endpackage

`default_nettype wire

/* hw/QuplsIsaPkg.sv */
`default_nettype none

package QuplsIsaPkg;

	// ========================================================================
	// Instruction word layout
	// ========================================================================

	// All instructions are a fixed 32 bits wide
	localparam int INSTR_W = 32;

	// A fetch block carries two instructions side by side
	localparam int FETCH_W = 2 * INSTR_W;

	// Opcode sits in the lowest seven bits
	localparam int OPCODE_LSB = 0;
	localparam int OPCODE_MSB = 6;
	localparam int OPCODE_W = OPCODE_MSB - OPCODE_LSB + 1;

	// Register fields are all six bits, giving 64 architectural registers
	localparam int REG_FIELD_W = 6;
	localparam int RD_LSB = 7;
	localparam int RD_MSB = 12;
	localparam int RS1_LSB = 13;
	localparam int RS1_MSB = 18;
	localparam int RS2_LSB = 19;
	localparam int RS2_MSB = 24;

	// The immediate overlays Rs2 and the spare upper bits
	localparam int IMM_LSB = 19;
	localparam int IMM_MSB = 31;
	localparam int IMM_FIELD_W = 13;

	typedef logic [INSTR_W-1:0] instrWord;

	// Lower-addressed instruction is in the low half
	typedef logic [FETCH_W-1:0] fetchBlock;

	// ========================================================================
	// Opcode map
	// ========================================================================

	// Register-only forms live at the bottom of the map, immediates above,
	// and all memory operations share the 7'h4x group
	typedef enum logic [OPCODE_W-1:0] {
		OP_NOP   = 7'h00,
		OP_ADD   = 7'h02,
		OP_SUB   = 7'h03,
		OP_AND   = 7'h04,
		OP_OR    = 7'h05,
		OP_ZSxxI = 7'h06,
		OP_ADDI  = 7'h10,
		OP_CMPI  = 7'h11,
		OP_MULI  = 7'h12,
		OP_DIVI  = 7'h13,
		OP_SUBFI = 7'h14,
		OP_DIVUI = 7'h15,
		OP_MULUI = 7'h16,
		OP_ANDI  = 7'h18,
		OP_ORI   = 7'h19,
		OP_EORI  = 7'h1A,
		OP_RTD   = 7'h20,
		OP_JSR   = 7'h21,
		OP_LDB   = 7'h40,
		OP_LDBU  = 7'h41,
		OP_LDW   = 7'h42,
		OP_LDWU  = 7'h43,
		OP_LDT   = 7'h44,
		OP_LDTU  = 7'h45,
		OP_LDO   = 7'h46,
		OP_CACHE = 7'h47,
		OP_STB   = 7'h48,
		OP_STW   = 7'h49,
		OP_STT   = 7'h4A,
		OP_STO   = 7'h4B
	} opcode_t;

endpackage

`default_nettype wire
